/* logic/mdu_pkg.sv */
package mdu_pkg;

	localparam int mdu_width = 32;
	localparam int div_cnt_width = $clog2(mdu_width); // One count per quotient bit

	typedef enum logic [3:0]
	{
		NOP,
		DIV,
		DIVU,
		MUL,
		MULT,
		MULTU,
		MFHI,
		MFLO,
		MTHI,
		MTLO
	} mdu_op_e;

	// Write source for HI and LO
	typedef enum logic [1:0]
	{
		OPERAND, // Operand a into the written register
		PRODUCT, // Product high word to HI, low word to LO
		DIVIDE   // Remainder to HI, quotient to LO
	} hilo_sel_e;

	typedef enum logic [1:0]
	{
		HI,
		LO,
		LOWR // Low word being written by MUL
	} out_sel_e;

	typedef struct packed
	{
		logic      hi_we;
		logic      lo_we;
		hilo_sel_e hilo_sel;
		out_sel_e  out_sel;
		logic      sign; // Signed multiply or divide
	} mdu_ctrl_t;

endpackage

/* logic/mdu_multiplier.sv */
module mdu_multiplier
(
	input  logic [mdu_pkg::mdu_width-1:0]   a_i,
	input  logic [mdu_pkg::mdu_width-1:0]   b_i,
	input  logic                            sign_i,
	output logic [2*mdu_pkg::mdu_width-1:0] product_o
);
	import mdu_pkg::*;

	logic signed [mdu_width:0] a_ext;
	logic signed [mdu_width:0] b_ext;
	logic signed [2*mdu_width+1:0] full;

	// Extra top bit makes one signed multiply cover both forms
	assign a_ext = {sign_i & a_i[mdu_width-1], a_i};
	assign b_ext = {sign_i & b_i[mdu_width-1], b_i};

	assign full = a_ext * b_ext;
	assign product_o = full[2*mdu_width-1:0]; // Upper bits are sign copies

endmodule

/* logic/mdu_divider.sv */
module mdu_divider
(
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic [mdu_pkg::mdu_width-1:0] dividend_i,
	input  logic [mdu_pkg::mdu_width-1:0] divisor_i,
	input  logic                          sign_i,
	input  logic                          start_i,
	output logic [mdu_pkg::mdu_width-1:0] quotient_o,
	output logic [mdu_pkg::mdu_width-1:0] remainder_o,
	output logic                          busy_o,
	output logic                          ready_o
);
	import mdu_pkg::*;

	logic [div_cnt_width-1:0] cnt_q;
	logic busy_q;
	logic ready_q;
	logic launch;
	logic [mdu_width-1:0] quo_q;
	logic [mdu_width-1:0] rem_q;
	logic [mdu_width-1:0] dsr_q;
	logic quo_neg_q;
	logic rem_neg_q;
	logic a_neg;
	logic b_neg;
	logic [mdu_width-1:0] a_mag;
	logic [mdu_width-1:0] b_mag;
	logic [mdu_width:0] shifted;
	logic [mdu_width:0] diff;

	assign launch = start_i & ~busy_q;

	assign a_neg = sign_i & dividend_i[mdu_width-1];
	assign b_neg = sign_i & divisor_i[mdu_width-1];
	assign a_mag = a_neg ? -dividend_i : dividend_i; // Signed minimum stays as its magnitude
	assign b_mag = b_neg ? -divisor_i : divisor_i;

	// Partial remainder with next dividend bit, then trial subtract
	assign shifted = {rem_q, quo_q[mdu_width-1]};
	assign diff = shifted - {1'b0, dsr_q};

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			busy_q <= 1'b0;
			ready_q <= 1'b0;
			cnt_q <= '0;
		end
		else if (launch)
		begin
			busy_q <= 1'b1;
			ready_q <= 1'b0;
			cnt_q <= '0;
		end
		else if (busy_q)
		begin
			cnt_q <= cnt_q + 1'b1;
			if (&cnt_q) // Last of the quotient bits
			begin
				busy_q <= 1'b0;
				ready_q <= 1'b1;
			end
		end
	end

	// Dividend shifts out of quo_q as quotient bits shift in
	always_ff @(posedge clk_i)
	begin
		if (launch)
		begin
			quo_q <= a_mag;
			rem_q <= '0;
			dsr_q <= b_mag;
			quo_neg_q <= a_neg ^ b_neg;
			rem_neg_q <= a_neg;
		end
		else if (busy_q)
		begin
			if (!diff[mdu_width])
			begin
				rem_q <= diff[mdu_width-1:0];
				quo_q <= {quo_q[mdu_width-2:0], 1'b1};
			end
			else
			begin
				rem_q <= shifted[mdu_width-1:0]; // Restore
				quo_q <= {quo_q[mdu_width-2:0], 1'b0};
			end
		end
	end

	assign quotient_o = quo_neg_q ? -quo_q : quo_q;
	assign remainder_o = rem_neg_q ? -rem_q : rem_q; // Follows dividend sign
	assign busy_o = busy_q;
	assign ready_o = ready_q;

endmodule

/* logic/mdu_ctrl.sv */
module mdu_ctrl
(
	input  logic               clk_i,
	input  logic               rst_i,
	input  mdu_pkg::mdu_op_e   op_i,
	input  logic               div_busy_i,
	input  logic               div_ready_i,
	output mdu_pkg::mdu_ctrl_t ctrl_o,
	output logic               div_start_o,
	output logic               stall_o
);
	import mdu_pkg::*;

	logic ready_q;
	logic done;

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			ready_q <= 1'b0;
		else
			ready_q <= div_ready_i;
	end

	assign done = div_ready_i & ~ready_q; // Only the first ready cycle

	always_comb
	begin
		ctrl_o.hi_we = 1'b0;
		ctrl_o.lo_we = 1'b0;
		ctrl_o.hilo_sel = OPERAND;
		ctrl_o.out_sel = HI;
		ctrl_o.sign = 1'b0;
		div_start_o = 1'b0;
		stall_o = 1'b0;
		case (op_i)
			DIV, DIVU:
			begin
				div_start_o = ~div_busy_i & ~done;
				stall_o = ~done;
				ctrl_o.hi_we = done; // Results land at the closing edge of done
				ctrl_o.lo_we = done;
				ctrl_o.hilo_sel = DIVIDE;
				ctrl_o.sign = (op_i == DIV);
			end
			MUL, MULT, MULTU:
			begin
				ctrl_o.hi_we = 1'b1;
				ctrl_o.lo_we = 1'b1;
				ctrl_o.hilo_sel = PRODUCT;
				ctrl_o.sign = (op_i != MULTU);
				if (op_i == MUL)
					ctrl_o.out_sel = LOWR;
			end
			MFLO:
				ctrl_o.out_sel = LO;
			MTHI:
				ctrl_o.hi_we = 1'b1;
			MTLO:
				ctrl_o.lo_we = 1'b1;
			default:
			begin
			end
		endcase
	end

endmodule

/* logic/mdu_hilo.sv */
module mdu_hilo
(
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  mdu_pkg::mdu_ctrl_t              ctrl_i,
	input  logic [mdu_pkg::mdu_width-1:0]   a_i,
	input  logic [2*mdu_pkg::mdu_width-1:0] product_i,
	input  logic [mdu_pkg::mdu_width-1:0]   quotient_i,
	input  logic [mdu_pkg::mdu_width-1:0]   remainder_i,
	output logic [mdu_pkg::mdu_width-1:0]   data_o
);
	import mdu_pkg::*;

	logic [mdu_width-1:0] hi_q;
	logic [mdu_width-1:0] lo_q;
	logic [mdu_width-1:0] hi_wdata;
	logic [mdu_width-1:0] lo_wdata;

	always_comb
	begin
		case (ctrl_i.hilo_sel)
			PRODUCT:
			begin
				hi_wdata = product_i[2*mdu_width-1:mdu_width];
				lo_wdata = product_i[mdu_width-1:0];
			end
			DIVIDE:
			begin
				hi_wdata = remainder_i;
				lo_wdata = quotient_i;
			end
			default:
			begin
				hi_wdata = a_i; // MTHI and MTLO
				lo_wdata = a_i;
			end
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			hi_q <= '0;
			lo_q <= '0;
		end
		else
		begin
			if (ctrl_i.hi_we)
				hi_q <= hi_wdata;
			if (ctrl_i.lo_we)
				lo_q <= lo_wdata;
		end
	end

	always_comb
	begin
		case (ctrl_i.out_sel)
			LO:      data_o = lo_q;
			LOWR:    data_o = lo_wdata; // MUL result in the same cycle
			default: data_o = hi_q;
		endcase
	end

endmodule

/* logic/mdu_top.sv */
module mdu_top
(
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  mdu_pkg::mdu_op_e              op_i,
	input  logic [mdu_pkg::mdu_width-1:0] a_i,
	input  logic [mdu_pkg::mdu_width-1:0] b_i,
	output logic [mdu_pkg::mdu_width-1:0] data_o,
	output logic                          stall_o
);
	import mdu_pkg::*;

	mdu_ctrl_t ctrl;
	logic div_start;
	logic div_busy;
	logic div_ready;
	logic [mdu_width-1:0] quotient;
	logic [mdu_width-1:0] remainder;
	logic [2*mdu_width-1:0] product;

	mdu_ctrl i_ctrl
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.op_i        (op_i),
		.div_busy_i  (div_busy),
		.div_ready_i (div_ready),
		.ctrl_o      (ctrl),
		.div_start_o (div_start),
		.stall_o     (stall_o)
	);

	mdu_hilo i_hilo
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.ctrl_i      (ctrl),
		.a_i         (a_i),
		.product_i   (product),
		.quotient_i  (quotient),
		.remainder_i (remainder),
		.data_o      (data_o)
	);

	mdu_multiplier i_mult
	(
		.a_i       (a_i),
		.b_i       (b_i),
		.sign_i    (ctrl.sign),
		.product_o (product)
	);

	mdu_divider i_div
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.dividend_i  (a_i),
		.divisor_i   (b_i),
		.sign_i      (ctrl.sign),
		.start_i     (div_start),
		.quotient_o  (quotient),
		.remainder_o (remainder),
		.busy_o      (div_busy),
		.ready_o     (div_ready)
	);

endmodule

/* include/mdu_tb_table.svh */
`ifndef MDU_TB_TABLE_SVH
`define MDU_TB_TABLE_SVH

// One stimulus row with exp checked only when chk is set
typedef struct packed
{
	mdu_pkg::mdu_op_e op;
	logic [31:0]      a;
	logic [31:0]      b;
	logic             chk;
	logic [31:0]      exp;
	logic [8*12-1:0]  name;
} tb_row_t;

localparam int tb_rows = 36;

localparam tb_row_t tb_table [tb_rows] = '{
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'h0,        "rst_hi"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'h0,        "rst_lo"},
	'{mdu_pkg::MTHI,  32'h12345678, 32'h0,        1'b0, 32'h0,        "mthi"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'h0,        "mthi_lo"},
	'{mdu_pkg::MTLO,  32'h9abcdef0, 32'h0,        1'b0, 32'h0,        "mtlo"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'h12345678, "mtlo_hi"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'h9abcdef0, "mtlo_lo"},
	'{mdu_pkg::MULT,  32'hfffffffd, 32'h7,        1'b0, 32'h0,        "mult"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'hffffffff, "mult_hi"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'hffffffeb, "mult_lo"},
	'{mdu_pkg::MULTU, 32'hfffffffd, 32'h7,        1'b0, 32'h0,        "multu"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'h6,        "multu_hi"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'hffffffeb, "multu_lo"},
	'{mdu_pkg::MUL,   32'h00010003, 32'hffff0002, 1'b1, 32'hffff0006, "mul_out"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'hfffffffe, "mul_hi"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'hffff0006, "mul_lo"},
	'{mdu_pkg::DIV,   32'hffffff9c, 32'h7,        1'b0, 32'h0,        "div"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'hfffffff2, "div_q"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'hfffffffe, "div_r"},
	'{mdu_pkg::DIVU,  32'hffffff9c, 32'h7,        1'b0, 32'h0,        "divu"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'h24924916, "divu_q"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'h2,        "divu_r"},
	'{mdu_pkg::DIV,   32'h80000000, 32'hffffffff, 1'b0, 32'h0,        "min_div"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'h80000000, "min_q"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'h0,        "min_r"},
	'{mdu_pkg::DIVU,  32'h00001234, 32'h0,        1'b0, 32'h0,        "div0_u"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'hffffffff, "div0_u_q"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'h00001234, "div0_u_r"},
	'{mdu_pkg::DIV,   32'hfffffff6, 32'h0,        1'b0, 32'h0,        "div0_s"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'h1,        "div0_s_q"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'hfffffff6, "div0_s_r"},
	'{mdu_pkg::DIV,   32'd100,      32'd9,        1'b0, 32'h0,        "b2b_first"},
	'{mdu_pkg::DIV,   32'hffffff9c, 32'hfffffff9, 1'b0, 32'h0,        "b2b_second"},
	'{mdu_pkg::MFLO,  32'h0,        32'h0,        1'b1, 32'he,        "b2b_q"},
	'{mdu_pkg::MFHI,  32'h0,        32'h0,        1'b1, 32'hfffffffe, "b2b_r"},
	'{mdu_pkg::NOP,   32'h0,        32'h0,        1'b0, 32'h0,        "idle"}
};

`endif

/* verification/mdu_tb.sv */
module mdu_tb;
	import mdu_pkg::*;

	`include "mdu_tb_table.svh"

	localparam int clk_period = 100;
	localparam int rst_cycles = 5;
	localparam int rnd_cases = 40;
	localparam int cycles_per_case = 40;
	localparam int div_stall_cycles = 33; // Op cycle plus 32 busy cycles
	localparam longint timeout_time = longint'(rst_cycles + tb_rows + rnd_cases)
		* cycles_per_case * clk_period;

	logic clk_i;
	logic rst_i;
	mdu_op_e op_i;
	logic [31:0] a_i;
	logic [31:0] b_i;
	logic [31:0] data_o;
	logic stall_o;

	mdu_top i_dut
	(
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.op_i    (op_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.data_o  (data_o),
		.stall_o (stall_o)
	);

	always #(clk_period/2) clk_i = ~clk_i;

	task automatic check_value(input logic [95:0] name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// Reference division with the remainder in the upper word and the quotient in the lower
	function automatic logic [63:0] div_model(input logic [31:0] a, input logic [31:0] b,
		input logic sign);
		logic a_neg;
		logic b_neg;
		logic [31:0] a_mag;
		logic [31:0] b_mag;
		logic [31:0] q;
		logic [31:0] r;
		a_neg = sign & a[31];
		b_neg = sign & b[31];
		a_mag = a_neg ? 32'(-a) : a;
		b_mag = b_neg ? 32'(-b) : b;
		if (b_mag == 32'h0)
		begin
			q = 32'hffffffff; // Divide by zero rule on the magnitudes
			r = a_mag;
		end
		else
		begin
			q = a_mag / b_mag;
			r = a_mag % b_mag;
		end
		if (a_neg ^ b_neg)
			q = -q;
		if (a_neg)
			r = -r;
		return {r, q};
	endfunction

	// Presents one op and waits until the pipeline may move on
	task automatic run_op(input mdu_op_e op, input logic [31:0] a, input logic [31:0] b,
		input logic chk, input logic [31:0] exp, input logic [95:0] name);
		int stall_cnt;
		logic is_div;
		stall_cnt = 0;
		is_div = (op == DIV) || (op == DIVU);
		@(posedge clk_i);
		op_i <= op;
		a_i <= a;
		b_i <= b;
		@(negedge clk_i);
		check_value(name, {31'b0, is_div}, {31'b0, stall_o}); // Stall only for divisions
		while (stall_o)
		begin
			stall_cnt++;
			@(negedge clk_i);
		end
		if (is_div)
			check_value(name, div_stall_cycles, 32'(stall_cnt));
		if (chk)
			check_value(name, exp, data_o);
	endtask

	initial
	begin
		#(timeout_time);
		$display("Timeout: the DUT did not finish the tests in the expected time");
		$display("Done: errors found");
		$fatal(1);
	end

	initial
	begin
		logic [31:0] ra;
		logic [31:0] rb;
		logic [63:0] expect_qr;
		mdu_op_e rop;
		clk_i = 1'b0;
		rst_i = 1'b1;
		op_i = NOP;
		a_i = '0;
		b_i = '0;
		void'($urandom(79464));
		repeat (rst_cycles) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		check_value("rst_stall", 32'h0, {31'b0, stall_o});
		for (int i = 0; i < tb_rows; i++)
			run_op(tb_table[i].op, tb_table[i].a, tb_table[i].b, tb_table[i].chk,
				tb_table[i].exp, tb_table[i].name);
		for (int i = 0; i < rnd_cases; i++)
		begin
			ra = $urandom;
			rb = $urandom;
			if (i % 8 == 0)
				rb = '0;
			else if (i % 3 == 1)
				rb = rb >> 20; // Small divisors give large quotients
			rop = ($urandom & 1) ? DIV : DIVU;
			expect_qr = div_model(ra, rb, rop == DIV);
			run_op(rop, ra, rb, 1'b0, 32'h0, "rnd_div");
			run_op(MFLO, 32'h0, 32'h0, 1'b1, expect_qr[31:0], "rnd_quot");
			run_op(MFHI, 32'h0, 32'h0, 1'b1, expect_qr[63:32], "rnd_rem");
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

/* mdu.f */
+incdir+include
logic/mdu_pkg.sv
logic/mdu_multiplier.sv
logic/mdu_divider.sv
logic/mdu_ctrl.sv
logic/mdu_hilo.sv
logic/mdu_top.sv
verification/mdu_tb.sv

/* Makefile */
# Verilator flow for the multiply/divide unit

VERILATOR  ?= verilator
TOP        ?= mdu_tb
LINT_TOP   ?= mdu_top
FILELIST   ?= mdu.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
